//--- Makefile
TB := tb_sigma_tile

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TB)

run: build
	@out=$$(./obj_dir/V$(TB)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

lint:
	verilator --lint-only --timing -f verilog.f --top-module sigma_tile

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- hw/bus_decoder.sv
// host bus decoder: routes requests to data ram or registers and steers read responses back
`timescale 1ns/1ps
`include "sigma_tile_config.svh"

module bus_decoder
    import sigma_tile_pkg::*;
(
    input  logic        clk_i
    , input  logic      rst_n_i

    , input  logic      host_req_i
    , input  mem_req_t  host_req_bus_i
    , output logic      host_ack_o
    , output mem_resp_t host_resp_o

    , output logic      dmem_req_o
    , output logic      sfr_req_o
    , output mem_req_t  slv_req_bus_o
    , input  logic      dmem_ack_i
    , input  logic      sfr_ack_i
    , input  mem_resp_t dmem_resp_i
    , input  mem_resp_t sfr_resp_i
);

    slave_sel_e sel;
    slave_sel_e rd_sel_q;
    logic       slv_ack;

    assign sel = host_req_bus_i.addr[`SFR_BITSEL] ? SEL_SFR : SEL_DMEM;

    assign dmem_req_o    = host_req_i && (sel == SEL_DMEM);
    assign sfr_req_o     = host_req_i && (sel == SEL_SFR);
    assign slv_req_bus_o = host_req_bus_i;

    assign slv_ack    = (sel == SEL_SFR) ? sfr_ack_i : dmem_ack_i;
    assign host_ack_o = host_req_i && slv_ack;

    // remember which slave took the read, its response follows next cycle
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rd_sel_q <= SEL_DMEM;
        end
        else if (host_req_i && slv_ack && !host_req_bus_i.we)
        begin
            rd_sel_q <= sel;
        end
    end

    assign host_resp_o = (rd_sel_q == SEL_SFR) ? sfr_resp_i : dmem_resp_i;

endmodule

//--- hw/data_ram.sv
// data ram: word-addressed single-port memory with byte enables and registered read response
`timescale 1ns/1ps
`include "sigma_tile_config.svh"

module data_ram
    import sigma_tile_pkg::*;
(
    input  logic        clk_i
    , input  logic      rst_n_i

    , input  logic      req_i
    , input  mem_req_t  req_bus_i
    , output logic      ack_o
    , output mem_resp_t resp_o
);

    localparam int ADDR_W = $clog2(`MEM_WORDS);

    logic [3:0][7:0]   mem [`MEM_WORDS];
    logic [ADDR_W-1:0] word_addr;
    logic              rd_q;
    data_t             rdata_q;

    // always ready
    assign ack_o     = req_i;
    assign word_addr = req_bus_i.addr[ADDR_W+1:2];

    always_ff @(posedge clk_i)
    begin
        if (req_i && req_bus_i.we)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (req_bus_i.be[i])
                    mem[word_addr][i] <= req_bus_i.wdata[i*8 +: 8];
            end
        end
        else if (req_i)
        begin
            rdata_q <= mem[word_addr];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            rd_q <= 1'b0;
        else
            rd_q <= req_i && !req_bus_i.we;
    end

    assign resp_o.resp  = rd_q;
    assign resp_o.rdata = rdata_q;

endmodule

//--- hw/irq_adapter.sv
// interrupt adapter: latches line edges and software interrupts, presents lowest pending code
`timescale 1ns/1ps
`include "sigma_tile_config.svh"

module irq_adapter
    import sigma_tile_pkg::*;
(
    input  logic        clk_i
    , input  logic      rst_n_i
    , input  logic      cpu_reset_i

    , input  irq_vec_t  irq_lines_i
    , input  logic      timer_irq_i
    , input  logic      sgi_req_i
    , input  irq_code_t sgi_code_i

    , output logic      irq_req_o
    , output irq_code_t irq_code_o
    , input  logic      irq_ack_i
);

    irq_vec_t lines;
    irq_vec_t lines_q;
    irq_vec_t edges;
    irq_vec_t sgi_set;
    irq_vec_t ack_clr;
    irq_vec_t pending_q;

    // timer joins the external lines
    assign lines = irq_lines_i | (irq_vec_t'(timer_irq_i) << `TIMER_IRQ_LINE);
    assign edges = lines & ~lines_q;

    assign sgi_set = sgi_req_i ? (irq_vec_t'(1) << sgi_code_i) : '0;
    assign ack_clr = (irq_ack_i && irq_req_o) ? (irq_vec_t'(1) << irq_code_o) : '0;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            lines_q   <= '0;
            pending_q <= '0;
        end
        else
        begin
            lines_q <= lines;
            if (cpu_reset_i)
                pending_q <= '0;
            else
                pending_q <= (pending_q & ~ack_clr) | edges | sgi_set;
        end
    end

    // lowest line wins
    always_comb
    begin
        irq_code_o = '0;
        for (int i = (2**`IRQ_NUM_POW) - 1; i >= 0; i--)
        begin
            if (pending_q[i])
                irq_code_o = irq_code_t'(i);
        end
    end

    assign irq_req_o = |pending_q;

endmodule

//--- hw/sfr_block.sv
// special-function registers: core id, processor reset, period timer, software interrupt
`timescale 1ns/1ps
`include "sigma_tile_config.svh"

module sfr_block
    import sigma_tile_pkg::*;
(
    input  logic        clk_i
    , input  logic      rst_n_i

    , input  logic      req_i
    , input  mem_req_t  req_bus_i
    , output logic      ack_o
    , output mem_resp_t resp_o

    , output logic      cpu_reset_o
    , output logic      timer_irq_o
    , output logic      sgi_req_o
    , output irq_code_t sgi_code_o
);

    localparam int OFF_W = `SFR_BITSEL;

    localparam logic [OFF_W-1:0] OFF_CORE_ID   = 'h00;
    localparam logic [OFF_W-1:0] OFF_CPU_RESET = 'h04;
    localparam logic [OFF_W-1:0] OFF_PERIOD    = 'h08;
    localparam logic [OFF_W-1:0] OFF_VALUE     = 'h0C;
    localparam logic [OFF_W-1:0] OFF_ENABLE    = 'h10;
    localparam logic [OFF_W-1:0] OFF_SGI       = 'h14;

    logic [OFF_W-1:0] offset;
    logic             wr;
    logic             rd;
    data_t            rdata_d;
    data_t            rdata_q;
    logic             resp_q;
    data_t            period_q;
    data_t            value_q;
    logic             enable_q;

    assign ack_o  = req_i;
    assign offset = req_bus_i.addr[OFF_W-1:0];
    assign wr     = req_i && req_bus_i.we;
    assign rd     = req_i && !req_bus_i.we;

    always_comb
    begin
        case (offset)
            OFF_CORE_ID:   rdata_d = data_t'(`CORENUM);
            OFF_CPU_RESET: rdata_d = data_t'(cpu_reset_o);
            OFF_PERIOD:    rdata_d = period_q;
            OFF_VALUE:     rdata_d = value_q;
            OFF_ENABLE:    rdata_d = data_t'(enable_q);
            default:       rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            resp_q      <= 1'b0;
            cpu_reset_o <= `CPU_RESET_DEFAULT;
            period_q    <= '0;
            value_q     <= '0;
            enable_q    <= 1'b0;
            timer_irq_o <= 1'b0;
            sgi_req_o   <= 1'b0;
        end
        else
        begin
            resp_q      <= rd;
            sgi_req_o   <= wr && (offset == OFF_SGI);
            timer_irq_o <= 1'b0;
            if (wr && (offset == OFF_CPU_RESET))
                cpu_reset_o <= req_bus_i.wdata[0];
            if (wr && (offset == OFF_PERIOD))
                period_q <= req_bus_i.wdata;
            if (wr && (offset == OFF_ENABLE))
                enable_q <= req_bus_i.wdata[0];
            // restart from zero when the count reaches the period
            if (enable_q)
            begin
                if (value_q == period_q)
                begin
                    value_q     <= '0;
                    timer_irq_o <= 1'b1;
                end
                else
                begin
                    value_q <= value_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rd)
            rdata_q <= rdata_d;
        if (wr && (offset == OFF_SGI))
            sgi_code_o <= req_bus_i.wdata[`IRQ_NUM_POW-1:0];
    end

    assign resp_o.resp  = resp_q;
    assign resp_o.rdata = rdata_q;

endmodule

//--- hw/sigma_tile.sv
// sigma tile top: host bus decode, data ram, register block and interrupt adapter
`timescale 1ns/1ps

module sigma_tile
    import sigma_tile_pkg::*;
(
    input  logic        clk_i
    , input  logic      rst_n_i

    , input  logic      host_req_i
    , input  mem_req_t  host_req_bus_i
    , output logic      host_ack_o
    , output mem_resp_t host_resp_o

    , input  irq_vec_t  irq_lines_i
    , output logic      irq_req_o
    , output irq_code_t irq_code_o
    , input  logic      irq_ack_i

    , output logic      cpu_reset_o
);

    logic      dmem_req;
    logic      sfr_req;
    mem_req_t  slv_req_bus;
    logic      dmem_ack;
    logic      sfr_ack;
    mem_resp_t dmem_resp;
    mem_resp_t sfr_resp;

    logic      timer_irq;
    logic      sgi_req;
    irq_code_t sgi_code;

    bus_decoder bus_decoder_inst (
        .clk_i            (clk_i)
        , .rst_n_i        (rst_n_i)
        , .host_req_i     (host_req_i)
        , .host_req_bus_i (host_req_bus_i)
        , .host_ack_o     (host_ack_o)
        , .host_resp_o    (host_resp_o)
        , .dmem_req_o     (dmem_req)
        , .sfr_req_o      (sfr_req)
        , .slv_req_bus_o  (slv_req_bus)
        , .dmem_ack_i     (dmem_ack)
        , .sfr_ack_i      (sfr_ack)
        , .dmem_resp_i    (dmem_resp)
        , .sfr_resp_i     (sfr_resp)
    );

    data_ram data_ram_inst (
        .clk_i       (clk_i)
        , .rst_n_i   (rst_n_i)
        , .req_i     (dmem_req)
        , .req_bus_i (slv_req_bus)
        , .ack_o     (dmem_ack)
        , .resp_o    (dmem_resp)
    );

    sfr_block sfr_block_inst (
        .clk_i         (clk_i)
        , .rst_n_i     (rst_n_i)
        , .req_i       (sfr_req)
        , .req_bus_i   (slv_req_bus)
        , .ack_o       (sfr_ack)
        , .resp_o      (sfr_resp)
        , .cpu_reset_o (cpu_reset_o)
        , .timer_irq_o (timer_irq)
        , .sgi_req_o   (sgi_req)
        , .sgi_code_o  (sgi_code)
    );

    irq_adapter irq_adapter_inst (
        .clk_i         (clk_i)
        , .rst_n_i     (rst_n_i)
        , .cpu_reset_i (cpu_reset_o)
        , .irq_lines_i (irq_lines_i)
        , .timer_irq_i (timer_irq)
        , .sgi_req_i   (sgi_req)
        , .sgi_code_i  (sgi_code)
        , .irq_req_o   (irq_req_o)
        , .irq_code_o  (irq_code_o)
        , .irq_ack_i   (irq_ack_i)
    );

endmodule

//--- hw/sigma_tile_config.svh
// sigma tile configuration: address split, memory size, core id, reset default, irq count
`ifndef SIGMA_TILE_CONFIG_SVH
`define SIGMA_TILE_CONFIG_SVH

// host address bit that selects the register block over the data ram
`define SFR_BITSEL 20

// data ram depth in 32-bit words
`define MEM_WORDS 1024

// value returned by the core id register
`define CORENUM 0

// processor reset level after rst_n_i
`define CPU_RESET_DEFAULT 1'b0

// log2 of interrupt line count
`define IRQ_NUM_POW 4

// line driven by the period timer
`define TIMER_IRQ_LINE 1

`endif

//--- hw/sigma_tile_pkg.sv
// sigma tile shared types: bus widths, split request/response structs, slave select
`include "sigma_tile_config.svh"

package sigma_tile_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;

    typedef logic [(2**`IRQ_NUM_POW)-1:0] irq_vec_t;
    typedef logic [`IRQ_NUM_POW-1:0]      irq_code_t;

    // request side, held by the master until ack
    typedef struct packed {
        logic  we;
        addr_t addr;
        be_t   be;
        data_t wdata;
    } mem_req_t;

    // read response, one cycle pulse
    typedef struct packed {
        logic  resp;
        data_t rdata;
    } mem_resp_t;

    typedef enum logic {
        SEL_DMEM = 1'b0,
        SEL_SFR  = 1'b1
    } slave_sel_e;

endpackage

//--- sim/tb_sigma_tile.sv
// sigma tile testbench: file-driven bus accesses, random ram traffic, reset, timer and irq checks
`timescale 1ns/1ps
`include "sigma_tile_config.svh"

module tb_sigma_tile
    import sigma_tile_pkg::*;
();

    localparam logic [31:0] SFR_BASE = 32'h1 << `SFR_BITSEL;
    localparam int MAX_OPS = 64;
    localparam int N_RAND  = 32;
    localparam int PERIOD  = 20;

    logic      clk_i;
    logic      rst_n_i;
    logic      host_req_i;
    mem_req_t  host_req_bus_i;
    logic      host_ack_o;
    mem_resp_t host_resp_o;
    irq_vec_t  irq_lines_i;
    logic      irq_req_o;
    irq_code_t irq_code_o;
    logic      irq_ack_i;
    logic      cpu_reset_o;

    // operations loaded from the input file
    string       names [MAX_OPS];
    logic        is_read [MAX_OPS];
    logic [31:0] addrs [MAX_OPS];
    logic [31:0] datas [MAX_OPS];
    logic [3:0]  bes [MAX_OPS];
    logic [31:0] exps [MAX_OPS];
    int          n_ops;

    data_t       model [`MEM_WORDS];
    int          rand_idx [N_RAND];
    logic [31:0] lcg_state;
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;

    initial
    begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    sigma_tile sigma_tile_inst (
        .clk_i            (clk_i)
        , .rst_n_i        (rst_n_i)
        , .host_req_i     (host_req_i)
        , .host_req_bus_i (host_req_bus_i)
        , .host_ack_o     (host_ack_o)
        , .host_resp_o    (host_resp_o)
        , .irq_lines_i    (irq_lines_i)
        , .irq_req_o      (irq_req_o)
        , .irq_code_o     (irq_code_o)
        , .irq_ack_i      (irq_ack_i)
        , .cpu_reset_o    (cpu_reset_o)
    );

    always @(posedge clk_i)
    begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit)
        begin
            $display("timeout after %0d cycles, errors: %0d", cycles, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic load_file();
        int              fd;
        int              r;
        int              c;
        logic [8*16-1:0] tok;
        logic [8*16-1:0] op;
        n_ops = 0;
        fd = $fopen("sim/tile_input.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open sim/tile_input.txt");
            return;
        end
        while (n_ops < MAX_OPS)
        begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1)
                break;
            // comment lines start with a lone hash
            if ($sformatf("%0s", tok) == "#")
            begin
                c = $fgetc(fd);
                while (c != 10 && c != -1)
                    c = $fgetc(fd);
                continue;
            end
            r = $fscanf(fd, "%s %h %h %h %h", op, addrs[n_ops], datas[n_ops], bes[n_ops],
                        exps[n_ops]);
            if (r != 5)
            begin
                errors++;
                $display("malformed line in input file after entry %0d", n_ops);
                break;
            end
            names[n_ops]   = $sformatf("%0s", tok);
            is_read[n_ops] = ($sformatf("%0s", op) == "read");
            if (!is_read[n_ops] && $sformatf("%0s", op) != "write")
            begin
                errors++;
                $display("unknown operation %0s in test %0s", op, tok);
            end
            n_ops++;
        end
        $fclose(fd);
    endtask

    task automatic drive_req(input logic we, input logic [31:0] addr, input data_t wdata,
                             input be_t be);
        host_req_i     <= 1'b1;
        host_req_bus_i <= '{we: we, addr: addr, be: be, wdata: wdata};
    endtask

    task automatic wait_ack(input logic [31:0] addr);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!host_ack_o && n < 16)
        begin
            @(negedge clk_i);
            n++;
        end
        assert (host_ack_o)
        else
        begin
            errors++;
            $display("no ack from the tile for address %h", addr);
        end
    endtask

    task automatic check_resp(input logic [31:0] addr);
        assert (host_resp_o.resp)
        else
        begin
            errors++;
            $display("no read response on the cycle after ack, address %h", addr);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input data_t wdata, input be_t be);
        @(posedge clk_i);
        drive_req(1'b1, addr, wdata, be);
        wait_ack(addr);
        @(posedge clk_i);
        host_req_i <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output data_t rdata);
        @(posedge clk_i);
        drive_req(1'b0, addr, '0, 4'hf);
        wait_ack(addr);
        @(posedge clk_i);
        host_req_i <= 1'b0;
        @(negedge clk_i);
        check_resp(addr);
        rdata = host_resp_o.rdata;
    endtask

    // second read transfers while the first one responds
    task automatic read_pair(input logic [31:0] addr_a, input logic [31:0] addr_b,
                             output data_t data_a, output data_t data_b);
        @(posedge clk_i);
        drive_req(1'b0, addr_a, '0, 4'hf);
        wait_ack(addr_a);
        @(posedge clk_i);
        drive_req(1'b0, addr_b, '0, 4'hf);
        @(negedge clk_i);
        check_resp(addr_a);
        data_a = host_resp_o.rdata;
        @(posedge clk_i);
        host_req_i <= 1'b0;
        @(negedge clk_i);
        check_resp(addr_b);
        data_b = host_resp_o.rdata;
    endtask

    task automatic wait_irq(input string name, input int max_cycles);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!irq_req_o && n < max_cycles)
        begin
            @(negedge clk_i);
            n++;
        end
        assert (irq_req_o)
        else
        begin
            errors++;
            $display("%s: no interrupt request within %0d cycles", name, max_cycles);
        end
    endtask

    task automatic ack_irq();
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic run_file_ops();
        data_t val;
        for (int i = 0; i < n_ops; i++)
        begin
            if (is_read[i])
            begin
                bus_read(addrs[i], val);
                check_value(names[i], exps[i], val);
            end
            else
            begin
                bus_write(addrs[i], datas[i], bes[i]);
            end
        end
    endtask

    task automatic run_random_ram();
        logic [31:0] r;
        data_t       da;
        data_t       db;
        for (int i = 0; i < N_RAND; i++)
        begin
            r = lcg_next();
            rand_idx[i] = int'(r[31:16]) % `MEM_WORDS;
            model[rand_idx[i]] = lcg_next();
            bus_write(32'(rand_idx[i] * 4), model[rand_idx[i]], 4'hf);
        end
        for (int i = 0; i < N_RAND; i += 2)
        begin
            read_pair(32'(rand_idx[i] * 4), 32'(rand_idx[i + 1] * 4), da, db);
            check_value("lcg_read_first", model[rand_idx[i]], da);
            check_value("lcg_read_second", model[rand_idx[i + 1]], db);
        end
    endtask

    task automatic run_cpu_reset();
        data_t val;
        bus_write(SFR_BASE + 32'h04, 32'd1, 4'hf);
        @(negedge clk_i);
        check_value("cpu_reset_set", 32'd1, 32'(cpu_reset_o));
        bus_read(SFR_BASE + 32'h04, val);
        check_value("cpu_reset_read", 32'd1, val);
        // software interrupt must be swallowed while the core is held
        bus_write(SFR_BASE + 32'h14, 32'd5, 4'hf);
        repeat (3) @(negedge clk_i);
        check_value("sgi_in_reset", 32'd0, 32'(irq_req_o));
        bus_write(SFR_BASE + 32'h04, 32'd0, 4'hf);
        @(negedge clk_i);
        check_value("cpu_reset_clear", 32'd0, 32'(cpu_reset_o));
        check_value("sgi_after_reset", 32'd0, 32'(irq_req_o));
    endtask

    task automatic run_timer();
        data_t val;
        int    start;
        bus_write(SFR_BASE + 32'h08, 32'(PERIOD), 4'hf);
        bus_write(SFR_BASE + 32'h10, 32'd1, 4'hf);
        wait_irq("timer_first", PERIOD + 4);
        check_value("timer_first_code", 32'(`TIMER_IRQ_LINE), 32'(irq_code_o));
        ack_irq();
        check_value("timer_ack_clear", 32'd0, 32'(irq_req_o));
        start = cycles;
        while (!irq_req_o && (cycles - start) <= PERIOD + 4)
        begin
            bus_read(SFR_BASE + 32'h0C, val);
            assert (val <= PERIOD)
            else
            begin
                errors++;
                $display("timer value %0d went above period %0d", val, PERIOD);
            end
        end
        assert (irq_req_o)
        else
        begin
            errors++;
            $display("no second timer interrupt within %0d cycles", PERIOD + 4);
        end
        check_value("timer_second_code", 32'(`TIMER_IRQ_LINE), 32'(irq_code_o));
        ack_irq();
        bus_read(SFR_BASE + 32'h10, val);
        check_value("timer_enable_read", 32'd1, val);
        bus_write(SFR_BASE + 32'h10, 32'd0, 4'hf);
        @(negedge clk_i);
        check_value("timer_quiet", 32'd0, 32'(irq_req_o));
    endtask

    task automatic run_priority();
        @(posedge clk_i);
        irq_lines_i <= 16'h0088;
        bus_write(SFR_BASE + 32'h14, 32'd5, 4'hf);
        wait_irq("priority", 8);
        // sgi lands two edges after its transfer
        repeat (2) @(negedge clk_i);
        for (int i = 0; i < 3; i++)
        begin
            check_value("priority_req", 32'd1, 32'(irq_req_o));
            check_value("priority_code", 32'(3 + 2 * i), 32'(irq_code_o));
            ack_irq();
        end
        check_value("priority_done", 32'd0, 32'(irq_req_o));
        @(posedge clk_i);
        irq_lines_i <= '0;
    endtask

    initial
    begin
        rst_n_i        <= 1'b0;
        host_req_i     <= 1'b0;
        host_req_bus_i <= '0;
        irq_lines_i    <= '0;
        irq_ack_i      <= 1'b0;
        lcg_state = 32'd16434;
        load_file();
        limit = 40 * n_ops + 2000;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value("reset_cpu", 32'(`CPU_RESET_DEFAULT), 32'(cpu_reset_o));
        check_value("reset_irq", 32'd0, 32'(irq_req_o));
        check_value("reset_resp", 32'd0, 32'(host_resp_o.resp));
        run_file_ops();
        run_random_ram();
        run_cpu_reset();
        run_timer();
        run_priority();
        $display("errors: %0d, cycles: %0d", errors, cycles);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- sim/tile_input.txt
# columns: test name, op (write/read), address, data, byte enables, expected read value (hex)
# address bit 20 selects the register block, data or expected is unused where the op ignores it
ram_full   write 00000010 a5a5a5a5 f 00000000
ram_full   read  00000010 00000000 f a5a5a5a5
ram_merge  write 00000010 11223344 5 00000000
ram_merge  read  00000010 00000000 f a522a544
ram_top    write 00000ffc 01234567 f 00000000
ram_top    write 00000ffc deadbeef c 00000000
ram_top    read  00000ffc 00000000 f dead4567
ram_low    write 00000000 cafef00d f 00000000
ram_low    write 00000000 000000ff 1 00000000
ram_low    read  00000000 00000000 f cafef0ff
core_id    read  00100000 00000000 f 00000000
undef_18   read  00100018 00000000 f 00000000
undef_40   read  00100040 00000000 f 00000000
cpu_rst_rd read  00100004 00000000 f 00000000
alias_ram  write 00000008 0badf00d f 00000000
alias_sfr  write 00100008 00000064 f 00000000
alias_sfr  write 00100010 00000000 f 00000000
period_rd  read  00100008 00000000 f 00000064
alias_ram  read  00000008 00000000 f 0badf00d
alias_keep read  00000010 00000000 f a522a544

//--- verilog.f
+incdir+hw
hw/sigma_tile_pkg.sv
hw/bus_decoder.sv
hw/data_ram.sv
hw/sfr_block.sv
hw/irq_adapter.sv
hw/sigma_tile.sv
sim/tb_sigma_tile.sv
